//--- hdl/intrp_macros.svh
`ifndef INTRP_MACROS_SVH
`define INTRP_MACROS_SVH

// Samples produced per command
`define INTRP_BATCH_SIZE 8

// Integer sample width; the slope is twice as wide
`define INTRP_SAMPLE_WIDTH 16

// Fraction bits of the fixed-point slope
`define INTRP_FRAC_BITS 16

// Entries in the command queue
`define INTRP_FIFO_DEPTH 4

`endif

//--- hdl/intrp_pkg.sv
`default_nettype none

`include "intrp_macros.svh"

package intrp_pkg;

    // One output sample in two's complement
    typedef logic signed [`INTRP_SAMPLE_WIDTH-1:0] sample_t;

    // Segment command from the host
    typedef struct packed {
        logic signed [`INTRP_SAMPLE_WIDTH-1:0]   x;     // Start sample
        logic signed [2*`INTRP_SAMPLE_WIDTH-1:0] slope; // Fixed point, FRAC_BITS fraction
    } seg_cmd_t;

    // One interpolated batch, element 0 is the first sample
    typedef sample_t [`INTRP_BATCH_SIZE-1:0] batch_t;

    // Request port handshake state
    typedef enum logic {
        req_idle,
        req_ack_high
    } req_state_e;

endpackage

`default_nettype wire

//--- hdl/seg_request_port.sv
`timescale 1ns/1ps
`default_nettype none

module seg_request_port (
    input  logic                clk,
    input  logic                rst,
    input  logic                req,
    input  intrp_pkg::seg_cmd_t seg,
    output logic                ack,
    output logic                push,
    output intrp_pkg::seg_cmd_t push_data,
    input  logic                full
);

    intrp_pkg::req_state_e state_q;
    intrp_pkg::req_state_e state_d;
    logic                  req_q;
    intrp_pkg::seg_cmd_t   seg_q;

    // The host side is sampled once before the handshake acts on it
    always_ff @(posedge clk) begin
        if (rst) begin
            req_q <= 1'b0;
        end else begin
            req_q <= req;
        end
    end

    always_ff @(posedge clk) begin
        seg_q <= seg; // Held stable by the host until ack
    end

    always_comb begin
        state_d = state_q;
        push    = 1'b0;
        case (state_q)
            intrp_pkg::req_idle: begin
                if (req_q && !full) begin
                    push    = 1'b1; // Written on the same edge that raises ack
                    state_d = intrp_pkg::req_ack_high;
                end
            end
            intrp_pkg::req_ack_high: begin
                if (!req_q) begin
                    state_d = intrp_pkg::req_idle;
                end
            end
            default: begin
                state_d = intrp_pkg::req_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= intrp_pkg::req_idle;
        end else begin
            state_q <= state_d;
        end
    end

    assign ack       = (state_q == intrp_pkg::req_ack_high);
    assign push_data = seg_q;

endmodule

`default_nettype wire

//--- hdl/seg_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "intrp_macros.svh"

module seg_fifo (
    input  logic                clk,
    input  logic                rst,
    input  logic                push,
    input  intrp_pkg::seg_cmd_t push_data,
    input  logic                pop,
    output intrp_pkg::seg_cmd_t front,
    output logic                empty,
    output logic                full
);

    localparam int DEPTH = `INTRP_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    intrp_pkg::seg_cmd_t mem [DEPTH];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [CNT_W-1:0]    count;
    logic                do_push;
    logic                do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    assign front = mem[rd_ptr]; // Valid only while not empty
    assign empty = (count == '0);
    assign full  = (count == CNT_W'(DEPTH));

endmodule

`default_nettype wire

//--- hdl/batch_interpolator.sv
`timescale 1ns/1ps
`default_nettype none

`include "intrp_macros.svh"

module batch_interpolator (
    input  logic                clk,
    input  logic                rst,
    input  intrp_pkg::seg_cmd_t front,
    input  logic                empty,
    output logic                pop,
    output intrp_pkg::batch_t   batch,
    output logic                out_valid,
    input  logic                out_ready
);

    localparam int BS    = `INTRP_BATCH_SIZE;
    localparam int SW    = `INTRP_SAMPLE_WIDTH;
    localparam int FRAC  = `INTRP_FRAC_BITS;
    // Room for slope times the largest lane index plus the shifted start
    localparam int ACC_W = 2 * SW + $clog2(BS) + 1;
    localparam logic signed [ACC_W-1:0] HALF = ACC_W'(1) <<< (FRAC - 1);

    logic                    v1_q;
    logic                    v2_q;
    logic                    ld1;
    logic                    ld2;
    logic                    ld3;
    logic signed [SW-1:0]    x1_q;
    logic signed [ACC_W-1:0] x_fix;
    logic signed [ACC_W-1:0] prod_q [BS];
    logic signed [ACC_W-1:0] sum_q  [BS];

    // A stage loads when it is empty or its contents move on this edge
    assign ld3 = !out_valid || out_ready;
    assign ld2 = !v2_q || ld3;
    assign ld1 = !v1_q || ld2;
    assign pop = !empty && ld1;

    assign x_fix = ACC_W'(x1_q) <<< FRAC; // Start sample in slope format

    always_ff @(posedge clk) begin
        if (rst) begin
            v1_q      <= 1'b0;
            v2_q      <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            if (ld1) begin
                v1_q <= pop;
            end
            if (ld2) begin
                v2_q <= v1_q;
            end
            if (ld3) begin
                out_valid <= v2_q;
            end
        end
    end

    // Stage 1 forms the per-lane increments
    always_ff @(posedge clk) begin
        if (pop) begin
            x1_q <= front.x;
            for (int i = 0; i < BS; i++) begin
                prod_q[i] <= $signed(front.slope) * ACC_W'(i);
            end
        end
    end

    // Stage 2 adds the start sample and the rounding half
    always_ff @(posedge clk) begin
        if (ld2 && v1_q) begin
            for (int i = 0; i < BS; i++) begin
                sum_q[i] <= prod_q[i] + x_fix + HALF;
            end
        end
    end

    // Stage 3 floors by arithmetic shift and wraps to the sample width
    always_ff @(posedge clk) begin
        if (ld3 && v2_q) begin
            for (int i = 0; i < BS; i++) begin
                batch[i] <= SW'(sum_q[i] >>> FRAC);
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/intrp_top.sv
`timescale 1ns/1ps
`default_nettype none

module intrp_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                req,
    input  intrp_pkg::seg_cmd_t seg,
    output logic                ack,
    output intrp_pkg::batch_t   batch,
    output logic                out_valid,
    input  logic                out_ready
);

    logic                push;
    logic                full;
    logic                empty;
    logic                pop;
    intrp_pkg::seg_cmd_t push_data;
    intrp_pkg::seg_cmd_t front;

    seg_request_port i_seg_request_port (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .seg       (seg),
        .ack       (ack),
        .push      (push),
        .push_data (push_data),
        .full      (full)
    );

    seg_fifo i_seg_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .front     (front),
        .empty     (empty),
        .full      (full)
    );

    batch_interpolator i_batch_interpolator (
        .clk       (clk),
        .rst       (rst),
        .front     (front),
        .empty     (empty),
        .pop       (pop),
        .batch     (batch),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

endmodule

`default_nettype wire

//--- sim/intrp_properties.sv
`timescale 1ns/1ps
`default_nettype none

module intrp_properties (
    input logic              clk,
    input logic              rst,
    input logic              req,
    input logic              ack,
    input intrp_pkg::batch_t batch,
    input logic              out_valid,
    input logic              out_ready
);

    int violations = 0; // Read by the testbench for its verdict

    ack_rise_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(ack) |-> $past(req))
    else begin
        violations++;
        $error("ack rose while req was low");
    end

    ack_fall_needs_req_low: assert property (@(posedge clk) disable iff (rst)
        $fell(ack) |-> !$past(req))
    else begin
        violations++;
        $error("ack fell while req was still high");
    end

    // A stalled batch must stay put until the sink takes it
    output_held_on_stall: assert property (@(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(batch)))
    else begin
        violations++;
        $error("batch or out_valid changed while the sink was stalling");
    end

    out_valid_low_in_reset: assert property (@(posedge clk) rst |=> !out_valid)
    else begin
        violations++;
        $error("out_valid was high during reset");
    end

endmodule

bind intrp_top intrp_properties i_intrp_properties (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .ack       (ack),
    .batch     (batch),
    .out_valid (out_valid),
    .out_ready (out_ready)
);

`default_nettype wire

//--- sim/intrp_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "intrp_macros.svh"

module intrp_tb;

    localparam int NUM_TESTS   = 5;
    localparam int CYCLE_LIMIT = 400 * NUM_TESTS + 100;
    localparam int BS          = `INTRP_BATCH_SIZE;
    // Cycles for a full FIFO and pipeline to empty into a ready sink, with margin
    localparam int DRAIN_LIMIT = 4 * (`INTRP_FIFO_DEPTH + 4);

    logic                clk;
    logic                rst;
    logic                req;
    intrp_pkg::seg_cmd_t seg;
    logic                ack;
    intrp_pkg::batch_t   batch;
    logic                out_valid;
    logic                out_ready;

    intrp_pkg::batch_t   expected_q [$];
    intrp_pkg::batch_t   exp_batch;
    logic                exp_avail;
    logic                ready_random;
    int                  cycle_count;
    int                  check_errors;
    int                  tests_passed;
    int                  tests_failed;

    intrp_top i_intrp_top (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .seg       (seg),
        .ack       (ack),
        .batch     (batch),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: no finish after %0d cycles, the DUT stopped responding", cycle_count);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        forever begin
            @(posedge clk);
            #1;
            if (ready_random) out_ready = 1'($urandom_range(1)); // Random sink stalls
        end
    end

    // Sample i is floor(x + slope * i + 1/2), wrapped to the sample width
    function automatic intrp_pkg::batch_t expected_batch(intrp_pkg::seg_cmd_t cmd);
        intrp_pkg::batch_t result;
        real               slope_r;
        real               value;
        longint            floored;
        slope_r = $itor(cmd.slope) / (2.0 ** `INTRP_FRAC_BITS);
        for (int i = 0; i < BS; i++) begin
            value     = $itor(cmd.x) + slope_r * i + 0.5;
            floored   = longint'($floor(value));
            result[i] = floored[`INTRP_SAMPLE_WIDTH-1:0];
        end
        return result;
    endfunction

    function automatic int first_bad_lane(intrp_pkg::batch_t got, intrp_pkg::batch_t want);
        for (int i = 0; i < BS; i++) begin
            if (got[i] !== want[i]) return i;
        end
        return -1;
    endfunction

    function automatic int total_errors();
        return check_errors + i_intrp_top.i_intrp_properties.violations;
    endfunction

    task automatic load_front();
        exp_avail = (expected_q.size() > 0);
        if (exp_avail) exp_batch = expected_q[0];
    endtask

    always @(posedge clk) begin
        if (!rst && out_valid && out_ready) begin
            if (expected_q.size() > 0) void'(expected_q.pop_front());
            load_front();
        end
    end

    batch_matches_expected: assert property (@(posedge clk) disable iff (rst)
        (out_valid && out_ready) |-> (exp_avail && batch == exp_batch))
    else begin
        check_errors++;
        if (!$sampled(exp_avail)) begin
            $display("Fail %0t: batch transferred with nothing expected", $time);
        end else begin
            $display("Fail %0t: batch mismatch in lane %0d", $time,
                     first_bad_lane($sampled(batch), $sampled(exp_batch)));
        end
    end

    // Full four-phase cycle, entered and left 1 ns after a rising edge
    task automatic send(input int x, input int slope);
        intrp_pkg::seg_cmd_t cmd;
        cmd.x     = `INTRP_SAMPLE_WIDTH'(x);
        cmd.slope = slope;
        expected_q.push_back(expected_batch(cmd));
        load_front();
        seg = cmd;
        req = 1'b1;
        while (!ack) begin
            @(posedge clk);
            #1;
        end
        req = 1'b0;
        while (ack) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic end_test(input string name, input int errors_before);
        int errors_now;
        int waited;
        waited = 0;
        while ((expected_q.size() > 0 || out_valid) && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (expected_q.size() != 0) begin
            check_errors++;
            $display("Scoreboard still holds %0d batches that never arrived",
                     expected_q.size());
            expected_q.delete();
            load_front();
        end
        errors_now = total_errors();
        if (errors_now == errors_before) begin
            tests_passed++;
            $display("Test %s: passed", name);
        end else begin
            tests_failed++;
            $display("Test %s: failed with %0d errors", name, errors_now - errors_before);
        end
    endtask

    initial begin
        int errors_before;
        void'($urandom(32'h7f58));
        rst          = 1'b1;
        req          = 1'b0;
        seg          = '0;
        out_ready    = 1'b1;
        ready_random = 1'b0;
        exp_avail    = 1'b0;
        exp_batch    = '0;
        check_errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        errors_before = total_errors();
        send(10, 32'sd98304); // Slope 1.5
        end_test("single_command", errors_before);

        errors_before = total_errors();
        send(-3, -32'sd49152); // Slope -0.75
        end_test("negative_rounding", errors_before);

        // One more command than the FIFO and the three stages can hold
        errors_before = total_errors();
        out_ready = 1'b0;
        fork
            begin
                for (int n = 0; n < `INTRP_FIFO_DEPTH + 4; n++) begin
                    send(100 * n - 350, 21845 * n - 70000);
                end
            end
        join_none
        while (!(i_intrp_top.full && req && !ack)) begin
            @(posedge clk);
            #1;
        end
        out_ready = 1'b1;
        wait fork;
        end_test("back_pressure", errors_before);

        errors_before = total_errors();
        ready_random = 1'b1;
        repeat (40) begin
            send(int'($urandom_range(2000)) - 1000,
                 int'($urandom_range(128 * 65536)) - 64 * 65536);
        end
        ready_random = 1'b0;
        out_ready    = 1'b1;
        end_test("random_stream", errors_before);

        errors_before = total_errors();
        out_ready = 1'b0;
        send(7, 32'sd65536);
        send(-20, 32'sd32768);
        send(300, -32'sd200000);
        // A fourth command stays mid-handshake, so only reset can drop ack
        seg.x     = 16'sd42;
        seg.slope = 32'sd65536;
        req       = 1'b1;
        while (!ack) begin
            @(posedge clk);
            #1;
        end
        rst = 1'b1;
        expected_q.delete(); // Queued commands are lost in reset
        load_front();
        repeat (8) @(posedge clk);
        #1;
        assert (!ack && !out_valid) else begin
            check_errors++;
            $display("Fail %0t: ack or out_valid high at the end of reset", $time);
        end
        req       = 1'b0;
        rst       = 1'b0;
        out_ready = 1'b1;
        send(-500, 32'sd163840);
        end_test("reset_recovery", errors_before);

        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && total_errors() == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+hdl
hdl/intrp_pkg.sv
hdl/seg_request_port.sv
hdl/seg_fifo.sv
hdl/batch_interpolator.sv
hdl/intrp_top.sv
sim/intrp_properties.sv
sim/intrp_tb.sv
